/* freeList.f */
design/FreeListPkg.sv
design/MultiWidthQueuePointer.sv
design/RegisterMultiPortRam.sv
design/MultiWidthFreeList.sv
design/RenameAllocator.sv
design/FreeListTop.sv
test/FreeListTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = FreeListTb
FILELIST = freeList.f
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* test/FreeListTb.sv */
// ########################################
// Free list testbench
// Table-driven allocation and release,
// checked against a reference tag queue
// ########################################

`timescale 1ns/1ps

module FreeListTb;

    localparam int NumRows = 24;
    localparam int ResetCycles = 10;
    localparam int ReadyTimeout = 20;
    localparam int RunTimeout = 200;
    localparam int DriveDelay = 2;

    typedef struct packed {
        logic [FreeListPkg::PopWidth-1:0] allocLanes;
        logic [FreeListPkg::PushWidth-1:0] releaseLanes;
        logic expStall;
        FreeListPkg::Count expCount;
    } TableRow;

    logic clk;
    logic rst;
    FreeListPkg::AllocReq allocReq;
    FreeListPkg::ReleaseReq releaseReq;
    FreeListPkg::AllocResp allocResp;
    logic stall;
    FreeListPkg::Count count;
    logic ready;

    TableRow rows [NumRows];
    // Reference model, free tags in head order and tags held by rename
    FreeListPkg::Tag freeQueue [$];
    FreeListPkg::Tag outstanding [$];
    int mismatchCount;
    int otherCount;
    int checkCount;
    logic tableDone;

    FreeListTop dut (
        .clk(clk),
        .rst(rst),
        .allocReq(allocReq),
        .releaseReq(releaseReq),
        .allocResp(allocResp),
        .stall(stall),
        .count(count),
        .ready(ready)
    );

    always #20 clk = ~clk;

    // Lanes, release lanes, stall and count seen during the row
    task automatic fillTable();
        rows[0] = '{2'b11, 2'b00, 1'b0, 5'd16};
        rows[1] = '{2'b00, 2'b00, 1'b0, 5'd14};
        rows[2] = '{2'b01, 2'b00, 1'b0, 5'd14};
        rows[3] = '{2'b10, 2'b00, 1'b0, 5'd13};
        rows[4] = '{2'b11, 2'b00, 1'b0, 5'd12};
        rows[5] = '{2'b11, 2'b00, 1'b0, 5'd10};
        rows[6] = '{2'b11, 2'b00, 1'b0, 5'd8};
        rows[7] = '{2'b11, 2'b00, 1'b0, 5'd6};
        rows[8] = '{2'b11, 2'b00, 1'b0, 5'd4};
        rows[9] = '{2'b01, 2'b00, 1'b0, 5'd2};
        rows[10] = '{2'b11, 2'b00, 1'b1, 5'd1};
        rows[11] = '{2'b00, 2'b00, 1'b0, 5'd1};
        rows[12] = '{2'b10, 2'b00, 1'b0, 5'd1};
        // Empty list, the tag released here is not usable yet
        rows[13] = '{2'b01, 2'b10, 1'b1, 5'd0};
        rows[14] = '{2'b00, 2'b11, 1'b0, 5'd1};
        rows[15] = '{2'b01, 2'b00, 1'b0, 5'd3};
        rows[16] = '{2'b11, 2'b01, 1'b0, 5'd2};
        rows[17] = '{2'b11, 2'b00, 1'b1, 5'd1};
        rows[18] = '{2'b01, 2'b11, 1'b0, 5'd1};
        rows[19] = '{2'b11, 2'b11, 1'b0, 5'd2};
        rows[20] = '{2'b11, 2'b00, 1'b0, 5'd2};
        rows[21] = '{2'b00, 2'b11, 1'b0, 5'd0};
        rows[22] = '{2'b10, 2'b10, 1'b0, 5'd2};
        rows[23] = '{2'b00, 2'b00, 1'b0, 5'd2};
    endtask

    task automatic compareValue(input string name, input logic [7:0] got,
                                input logic [7:0] expected);
        checkCount++;
        assert (got === expected) else begin
            $display("MISMATCH %s: got %h, expected %h", name, got, expected);
            mismatchCount++;
        end
    endtask

    task automatic applyRow(input int r);
        TableRow row;
        FreeListPkg::Tag released [$];
        int pick;
        int popped;
        logic modelStall;
        row = rows[r];
        allocReq.valid = row.allocLanes;
        releaseReq = '0;
        for (int i = 0; i < FreeListPkg::PushWidth; i++) begin
            if (row.releaseLanes[i] && outstanding.size() == 0) begin
                $display("Row %0d releases a tag but no tag is outstanding", r);
                otherCount++;
            end else if (row.releaseLanes[i]) begin
                pick = int'($urandom % outstanding.size());
                releaseReq.valid[i] = 1'b1;
                releaseReq.tags[i] = outstanding[pick];
                released.push_back(outstanding[pick]);
                outstanding.delete(pick);
            end
        end
        modelStall = $countones(row.allocLanes) > freeQueue.size();

        // Outputs are combinational and settled by the falling edge
        @(negedge clk);
        assert (ready === 1'b1) else begin
            $display("Row %0d: ready was low while the table was running", r);
            otherCount++;
        end
        compareValue("stall", 8'(stall), 8'(row.expStall));
        compareValue("count", 8'(count), 8'(row.expCount));
        compareValue("count against model", 8'(count), 8'(freeQueue.size()));
        compareValue("allocResp.granted", 8'(allocResp.granted),
                     modelStall ? 8'h00 : 8'(row.allocLanes));
        popped = 0;
        for (int i = 0; i < FreeListPkg::PopWidth; i++) begin
            if (!modelStall && row.allocLanes[i]) begin
                compareValue($sformatf("allocResp.tags[%0d]", i),
                             8'(allocResp.tags[i]), 8'(freeQueue[popped]));
                popped++;
            end
        end

        // Pops leave from the head before this cycle's releases join the tail
        for (int k = 0; k < popped; k++) begin
            outstanding.push_back(freeQueue.pop_front());
        end
        foreach (released[k]) begin
            freeQueue.push_back(released[k]);
        end
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (tableDone !== 1'b1 && cycles < RunTimeout) begin
            @(posedge clk);
            cycles++;
        end
        if (tableDone !== 1'b1) begin
            $display("Run timed out after %0d cycles before the table finished", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin : mainFlow
        int waitCycles;
        void'($urandom(32'haf5c));
        clk = 1'b0;
        rst = 1'b0;
        allocReq = '0;
        releaseReq = '0;
        tableDone = 1'b0;
        mismatchCount = 0;
        otherCount = 0;
        checkCount = 0;
        fillTable();

        // One idle edge so the registered reset copy is known before reset
        @(posedge clk);
        #DriveDelay;
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #DriveDelay;
        rst = 1'b0;

        waitCycles = 0;
        while (ready !== 1'b1 && waitCycles < ReadyTimeout) begin
            @(posedge clk);
            #DriveDelay;
            waitCycles++;
        end
        if (ready !== 1'b1) begin
            $display("ready never rose after reset, gave up after %0d cycles", waitCycles);
            $display("Checks failed");
            $finish;
        end else begin
            for (int i = 0; i < FreeListPkg::FreeListSize; i++) begin
                freeQueue.push_back(FreeListPkg::Tag'(i));
            end
            for (int r = 0; r < NumRows; r++) begin
                applyRow(r);
                @(posedge clk);
                #DriveDelay;
            end
            allocReq = '0;
            releaseReq = '0;
            tableDone = 1'b1;
            $display("Done: %0d checks, %0d mismatches, %0d other errors",
                     checkCount, mismatchCount, otherCount);
            if (mismatchCount == 0 && otherCount == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

endmodule

/* design/FreeListTop.sv */
// ######################################
// Free list top level
// Allocator in front of the free list
// ######################################

`timescale 1ns/1ps

module FreeListTop (
    input  logic                   clk,
    input  logic                   rst,
    input  FreeListPkg::AllocReq   allocReq,
    input  FreeListPkg::ReleaseReq releaseReq,
    output FreeListPkg::AllocResp  allocResp,
    output logic                   stall,
    output FreeListPkg::Count      count,
    output logic                   ready
);

    logic [FreeListPkg::PopWidth-1:0] pop;
    FreeListPkg::Tag [FreeListPkg::PopWidth-1:0] poppedTags;

    RenameAllocator allocator (
        .allocReq(allocReq),
        .count(count),
        .ready(ready),
        .poppedTags(poppedTags),
        .pop(pop),
        .allocResp(allocResp),
        .stall(stall)
    );

    // Commit releases feed the push lanes directly
    MultiWidthFreeList freeList (
        .clk(clk),
        .rst(rst),
        .push(releaseReq.valid),
        .pushedTags(releaseReq.tags),
        .pop(pop),
        .count(count),
        .poppedTags(poppedTags),
        .ready(ready)
    );

endmodule

/* design/RenameAllocator.sv */
// ######################################
// Rename group allocator
// Grants a whole group of tags or stalls
// ######################################

`timescale 1ns/1ps

module RenameAllocator (
    input  FreeListPkg::AllocReq                        allocReq,
    input  FreeListPkg::Count                           count,
    input  logic                                        ready,
    input  FreeListPkg::Tag [FreeListPkg::PopWidth-1:0] poppedTags,
    output logic [FreeListPkg::PopWidth-1:0]            pop,
    output FreeListPkg::AllocResp                       allocResp,
    output logic                                        stall
);

    FreeListPkg::LaneCount reqCount;

    always_comb begin
        reqCount = '0;
        for (int i = 0; i < FreeListPkg::PopWidth; i++) begin
            if (allocReq.valid[i]) begin
                reqCount = reqCount + 1'b1;
            end
        end

        // All or nothing, a partial group is never granted
        stall = !ready || (FreeListPkg::Count'(reqCount) > count);
        pop = stall ? '0 : allocReq.valid;

        allocResp.granted = pop;
        // Tags already compacted by the free list
        allocResp.tags = poppedTags;
    end

endmodule

/* design/MultiWidthFreeList.sv */
// ######################################
// Multi-width physical register free list
// Circular queue of tags with compacted
// push and pop lanes and a reset walker
// ######################################

`timescale 1ns/1ps

module MultiWidthFreeList (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic [FreeListPkg::PushWidth-1:0]             push,
    input  FreeListPkg::Tag [FreeListPkg::PushWidth-1:0]  pushedTags,
    input  logic [FreeListPkg::PopWidth-1:0]              pop,
    output FreeListPkg::Count                             count,
    output FreeListPkg::Tag [FreeListPkg::PopWidth-1:0]   poppedTags,
    output logic                                          ready
);

    FreeListPkg::Index headPtr;
    FreeListPkg::Index tailPtr;
    FreeListPkg::LaneCount pushCount;
    FreeListPkg::LaneCount popCount;

    logic [FreeListPkg::PushWidth-1:0] we;
    FreeListPkg::Index [FreeListPkg::PushWidth-1:0] wa;
    FreeListPkg::Tag [FreeListPkg::PushWidth-1:0] wv;
    FreeListPkg::Index [FreeListPkg::PopWidth-1:0] ra;
    FreeListPkg::Tag [FreeListPkg::PopWidth-1:0] rv;

    logic rstQ;
    logic rstStart;
    FreeListPkg::Count rstIndex;
    FreeListPkg::Count walkIndex;
    FreeListPkg::Count walkAddr;

    MultiWidthQueuePointer queuePointer (
        .clk(clk),
        .rst(rst),
        .pushCount(pushCount),
        .popCount(popCount),
        .headPtr(headPtr),
        .tailPtr(tailPtr),
        .count(count)
    );

    RegisterMultiPortRam freeListRam (
        .clk(clk),
        .we(we),
        .wa(wa),
        .wv(wv),
        .ra(ra),
        .rv(rv)
    );

    // First cycle of reset starts the walker from entry 0
    assign rstStart = rst && !rstQ;
    assign walkIndex = rstStart ? '0 : rstIndex;
    assign ready = !rstQ;

    always_ff @(posedge clk) begin
        rstQ <= rst;
        if (rst && walkIndex < FreeListPkg::Count'(FreeListPkg::FreeListSize)) begin
            rstIndex <= walkIndex + FreeListPkg::Count'(FreeListPkg::PushWidth);
        end else if (!rst) begin
            rstIndex <= '0;
        end
    end

    always_comb begin
        walkAddr = '0;

        // Valid releases go to consecutive tail entries
        pushCount = '0;
        for (int i = 0; i < FreeListPkg::PushWidth; i++) begin
            wa[i] = FreeListPkg::wrapAdd(tailPtr, pushCount);
            wv[i] = pushedTags[i];
            we[i] = push[i];
            if (push[i]) begin
                pushCount = pushCount + 1'b1;
            end
        end

        // Head and head plus one are always read
        for (int i = 0; i < FreeListPkg::PopWidth; i++) begin
            ra[i] = FreeListPkg::wrapAdd(headPtr, FreeListPkg::LaneCount'(i));
        end

        // Lane k takes the read past the granted lanes below it
        popCount = '0;
        for (int i = 0; i < FreeListPkg::PopWidth; i++) begin
            poppedTags[i] = rv[popCount[0]];
            if (pop[i]) begin
                popCount = popCount + 1'b1;
            end
        end

        if (rst) begin
            for (int i = 0; i < FreeListPkg::PushWidth; i++) begin
                walkAddr = walkIndex + FreeListPkg::Count'(i);
                wa[i] = FreeListPkg::Index'(walkAddr);
                wv[i] = FreeListPkg::Tag'(walkAddr);
                // cut off writes past the last entry
                we[i] = walkAddr < FreeListPkg::Count'(FreeListPkg::FreeListSize);
            end
        end
    end

    // Commit never returns more tags than are outstanding
    assert property (@(posedge clk) disable iff (rst)
        int'(count) + int'(pushCount) <= FreeListPkg::FreeListSize)
        else $error("release of %0d overfills list at count %0d", pushCount, count);

endmodule

/* design/RegisterMultiPortRam.sv */
// ######################################
// Register-based multi-port RAM
// Two synchronous writes and two
// combinational reads per cycle
// ######################################

`timescale 1ns/1ps

module RegisterMultiPortRam (
    input  logic                                         clk,
    input  logic [FreeListPkg::PushWidth-1:0]            we,
    input  FreeListPkg::Index [FreeListPkg::PushWidth-1:0] wa,
    input  FreeListPkg::Tag [FreeListPkg::PushWidth-1:0]   wv,
    input  FreeListPkg::Index [FreeListPkg::PopWidth-1:0]  ra,
    output FreeListPkg::Tag [FreeListPkg::PopWidth-1:0]    rv
);

    FreeListPkg::Tag mem [FreeListPkg::FreeListSize];

    always_ff @(posedge clk) begin
        for (int i = 0; i < FreeListPkg::PushWidth; i++) begin
            if (we[i]) begin
                mem[wa[i]] <= wv[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < FreeListPkg::PopWidth; i++) begin
            rv[i] = mem[ra[i]];
        end
    end

    // Compacted lanes always land on distinct entries
    assert property (@(posedge clk) !(we[0] && we[1] && wa[0] == wa[1]))
        else $error("write ports collide at entry %0d", wa[0]);

endmodule

/* design/MultiWidthQueuePointer.sv */
// ######################################
// Multi-width queue pointer
// Head, tail and occupancy that move by a
// variable number of entries per cycle
// ######################################

`timescale 1ns/1ps

module MultiWidthQueuePointer (
    input  logic                  clk,
    input  logic                  rst,
    input  FreeListPkg::LaneCount pushCount,
    input  FreeListPkg::LaneCount popCount,
    output FreeListPkg::Index     headPtr,
    output FreeListPkg::Index     tailPtr,
    output FreeListPkg::Count     count
);

    FreeListPkg::Index headNext;
    FreeListPkg::Index tailNext;
    FreeListPkg::Count countNext;

    always_comb begin
        headNext = FreeListPkg::wrapAdd(headPtr, popCount);
        tailNext = FreeListPkg::wrapAdd(tailPtr, pushCount);
        // Pops and pushes of the same cycle both apply
        countNext = count + FreeListPkg::Count'(pushCount)
                  - FreeListPkg::Count'(popCount);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // List starts full, so tail sits on head
            headPtr <= '0;
            tailPtr <= '0;
            count <= FreeListPkg::Count'(FreeListPkg::FreeListSize);
        end else begin
            headPtr <= headNext;
            tailPtr <= tailNext;
            count <= countNext;
        end
    end

    // The allocator must have checked the group against count
    assert property (@(posedge clk) disable iff (rst)
        FreeListPkg::Count'(popCount) <= count)
        else $error("pop of %0d with only %0d free", popCount, count);

    // Returned tags never overfill the list
    assert property (@(posedge clk) disable iff (rst)
        ##1 count <= FreeListPkg::Count'(FreeListPkg::FreeListSize))
        else $error("count %0d above list size", count);

endmodule

/* design/FreeListPkg.sv */
// ######################################
// Free list shared definitions
// Widths, tag types and the request and
// response groups of the rename stage
// ######################################

package FreeListPkg;

    localparam int FreeListSize = 16;
    localparam int TagBits = 4;
    localparam int PushWidth = 2;
    localparam int PopWidth = 2;

    typedef logic [TagBits-1:0] Tag;
    typedef logic [$clog2(FreeListSize)-1:0] Index;
    // One extra bit so a full list can report 16
    typedef logic [$clog2(FreeListSize):0] Count;
    typedef logic [1:0] LaneCount;

    typedef struct packed {
        logic [PopWidth-1:0] valid;
    } AllocReq;

    typedef struct packed {
        logic [PopWidth-1:0] granted;
        Tag [PopWidth-1:0] tags;
    } AllocResp;

    typedef struct packed {
        logic [PushWidth-1:0] valid;
        Tag [PushWidth-1:0] tags;
    } ReleaseReq;

    // Circular index step, wraps at the end of the array
    function automatic Index wrapAdd(Index base, LaneCount offset);
        Count sum;
        sum = Count'(base) + Count'(offset);
        if (sum >= Count'(FreeListSize)) begin
            sum = sum - Count'(FreeListSize);
        end
        return Index'(sum);
    endfunction

endpackage
